// File: bench/fpuAddBench.sv
// Stimulus keeps every exact result representable, so the single guard-bit rounding never fires.
`default_nettype none

module fpuAddBench
	import fpuPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int addSubCases = 200;
	localparam int cancelCases = 20;
	localparam int i2fFixed = 12;
	localparam int i2fRandom = 40;
	localparam int streamOps = 100;
	localparam int streamIdle = 10;
	localparam int pressureOps = 100;
	localparam int holdOps = 4;
	localparam int totalOps = addSubCases + 2 * cancelCases + i2fFixed + i2fRandom
		+ streamOps + streamIdle + pressureOps + holdOps;
	localparam int cycleLimit = 4 * totalOps + 200;

	logic clock;
	logic rst;
	logic opValid;
	logic opReady;
	fpuOp op;
	logic [63:0] rn;
	logic [63:0] rm;
	logic resValid;
	logic resReady;
	logic [63:0] result;

	integer seed;
	int cycleCount = 0;
	int passCount = 0;
	int failCount = 0;
	int testChecks = 0;
	int testFails = 0;
	int resultCount = 0;
	int readyMode = 0;
	logic latencyCheck = 1'b0;
	logic [63:0] expQueue[$];
	int acceptQueue[$];

	// Integer conversion inputs, chosen to exercise both the byte and the bit normalize steps.
	logic [63:0] i2fValues [i2fFixed] = '{
		64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, 64'hFFFF_FFFF_FFFF_FFFF,
		64'h0000_0000_0000_00FF, 64'h0000_0000_0000_0100, 64'h0000_0000_0000_0101,
		64'h0010_0000_0000_0000, 64'hFFF0_0000_0000_0000, 64'h001F_FFFF_FFFF_FFFF,
		64'hFFE0_0000_0000_0001, 64'h0000_0123_4567_89AB, 64'hFFFF_FFFF_FFFF_FF80
	};

	fpuAddTop dut
	(
		.clock(clock),
		.rst(rst),
		.opValid(opValid),
		.opReady(opReady),
		.op(op),
		.rn(rn),
		.rm(rm),
		.resValid(resValid),
		.resReady(resReady),
		.result(result)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ########################################
	// Reference model
	// ########################################

	function automatic real powerOfTwo(input int e);
		real p;
		p = 1.0;
		for (int i = 0; i < e; i++)
			p = p * 2.0;
		for (int i = 0; i < -e; i++)
			p = p / 2.0;
		return p;
	endfunction

	// A far smaller operand shifts out entirely, so the larger one comes back unchanged.
	function automatic logic [63:0] expectedResult(input fpuOp o, input logic [63:0] a,
		input logic [63:0] b);
		logic [63:0] bb;
		longint iv;
		int ea;
		int eb;
		real r;
		if (o == opI2f)
		begin
			iv = a;
			r = $itor(iv);
		end
		else
		begin
			bb = (o == opSub) ? {~b[63], b[62:0]} : b;
			ea = int'(a[62:52]);
			eb = int'(b[62:52]);
			if (ea != 0 && eb != 0 && ea - eb > maxAlignShift)
				return a;
			if (ea != 0 && eb != 0 && eb - ea > maxAlignShift)
				return bb;
			r = $bitstoreal(a) + $bitstoreal(bb);
		end
		if (r == 0.0)
			return 64'd0;
		return $realtobits(r);
	endfunction

	// ########################################
	// Stimulus helpers
	// ########################################

	function automatic logic [63:0] randomScaled();
		int mag;
		int shift;
		mag = $random(seed) % 1000;
		shift = $random(seed) % 21;
		return $realtobits(real'(mag) * powerOfTwo(shift));
	endfunction

	function automatic logic [63:0] randomInteger();
		int width;
		logic [63:0] v;
		width = 1 + (($random(seed) & 63) % 53);
		v = {$random(seed), $random(seed)};
		v = v & ((64'd1 << width) - 64'd1);
		if ($random(seed) & 1)
			v = -v;
		return v;
	endfunction

	// Exponents more than 60 apart, in a random order.
	task automatic wideOperands(output logic [63:0] a, output logic [63:0] b);
		int magBig;
		int magSmall;
		logic [63:0] bigValue;
		logic [63:0] smallValue;
		magBig = ($random(seed) & 511) + 1;
		magSmall = ($random(seed) & 511) + 1;
		if ($random(seed) & 1)
			magBig = -magBig;
		if ($random(seed) & 1)
			magSmall = -magSmall;
		bigValue = $realtobits(real'(magBig) * powerOfTwo(35 + ($random(seed) & 3)));
		smallValue = $realtobits(real'(magSmall) * powerOfTwo(-35 - ($random(seed) & 3)));
		if ($random(seed) & 1)
		begin
			a = bigValue;
			b = smallValue;
		end
		else
		begin
			a = smallValue;
			b = bigValue;
		end
	endtask

	task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		testChecks++;
		if (actual !== expected)
		begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			failCount++;
			testFails++;
		end
		else
			passCount++;
	endtask

	// Called and returns 1 ns after a rising edge; ready is sampled at the falling edge.
	task automatic issueOp(input fpuOp o, input logic [63:0] a, input logic [63:0] b);
		logic taken;
		int acceptCycle;
		opValid = 1'b1;
		op = o;
		rn = a;
		rm = b;
		taken = 1'b0;
		acceptCycle = 0;
		while (!taken)
		begin
			@(negedge clock);
			taken = opReady;
			acceptCycle = cycleCount;
			@(posedge clock);
		end
		if (o != opNone)
		begin
			expQueue.push_back(expectedResult(o, a, b));
			acceptQueue.push_back(acceptCycle);
		end
		#1;
	endtask

	task automatic idleCycle();
		opValid = 1'b0;
		op = opNone;
		@(posedge clock);
		#1;
	endtask

	// A few extra cycles after the queue empties expose any surplus result.
	task automatic drainResults();
		opValid = 1'b0;
		op = opNone;
		while (expQueue.size() != 0)
		begin
			@(posedge clock);
			#1;
		end
		repeat (6)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic startTest();
		testChecks = 0;
		testFails = 0;
	endtask

	task automatic finishTest(input string name);
		drainResults();
		$display("%s finished: %0d checks, %0d failed", name, testChecks, testFails);
	endtask

	// ########################################
	// Output side
	// ########################################

	// Mode 0 keeps resReady high, mode 1 toggles it at random, mode 2 holds it low.
	initial
	begin
		resReady = 1'b1;
		forever
		begin
			@(posedge clock);
			#1;
			if (readyMode == 0)
				resReady = 1'b1;
			else if (readyMode == 1)
				resReady = $random(seed) & 1;
			else
				resReady = 1'b0;
		end
	end

	initial
	begin
		logic [63:0] expected;
		int acceptCycle;
		forever
		begin
			@(negedge clock);
			if (resValid === 1'b1 && resReady === 1'b1)
			begin
				if (expQueue.size() == 0)
				begin
					$display("A result %h appeared at %0t ns with no operation pending.",
						result, $time);
					failCount++;
					testFails++;
				end
				else
				begin
					expected = expQueue.pop_front();
					acceptCycle = acceptQueue.pop_front();
					checkValue(result, expected, "result");
					if (latencyCheck)
						checkValue(64'(cycleCount - acceptCycle), 64'd4, "latency");
				end
				resultCount++;
			end
		end
	end

	initial
	begin
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d cycles.", cycleLimit);
		$display("Simulation failed");
		$finish;
	end

	// ########################################
	// Test sequence
	// ########################################

	initial
	begin
		logic [63:0] a;
		logic [63:0] b;
		int startCount;
		int streamStart;
		seed = 32'h78d320e6;
		rst = 1'b1;
		opValid = 1'b0;
		op = opNone;
		rn = 64'd0;
		rm = 64'd0;
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;

		startTest();
		@(negedge clock);
		checkValue(64'(resValid), 64'd0, "resValid after reset");
		checkValue(64'(opReady), 64'd1, "opReady after reset");
		@(posedge clock);
		#1;
		finishTest("reset");

		startTest();
		for (int i = 0; i < addSubCases; i++)
		begin
			if (i % 8 == 7)
				wideOperands(a, b);
			else
			begin
				a = randomScaled();
				b = randomScaled();
			end
			issueOp(($random(seed) & 1) ? opSub : opAdd, a, b);
		end
		finishTest("add and subtract");

		startTest();
		for (int i = 0; i < cancelCases; i++)
		begin
			a = randomScaled();
			issueOp(opSub, a, a);
			issueOp(opAdd, a, {~a[63], a[62:0]});
		end
		finishTest("cancellation");

		startTest();
		for (int i = 0; i < i2fFixed; i++)
			issueOp(opI2f, i2fValues[i], 64'd0);
		for (int i = 0; i < i2fRandom; i++)
			issueOp(opI2f, randomInteger(), 64'd0);
		finishTest("integer conversion");

		// Every item in the stream is taken on its first cycle, and every result
		// must take exactly four edges from its accept.
		startTest();
		latencyCheck = 1'b1;
		startCount = resultCount;
		streamStart = cycleCount;
		for (int i = 0; i < streamOps; i++)
		begin
			if (i % 10 == 5)
				issueOp(opNone, randomScaled(), randomScaled());
			issueOp(($random(seed) & 1) ? opSub : opAdd, randomScaled(), randomScaled());
		end
		checkValue(64'(cycleCount - streamStart), 64'(streamOps + streamIdle),
			"stream issue cycles");
		drainResults();
		latencyCheck = 1'b0;
		checkValue(64'(resultCount - startCount), 64'(streamOps), "stream result count");
		finishTest("back-to-back stream");

		startTest();
		readyMode = 1;
		idleCycle();
		for (int i = 0; i < pressureOps; i++)
		begin
			if (($random(seed) & 3) == 0)
				idleCycle();
			issueOp(($random(seed) & 1) ? opSub : opAdd, randomScaled(), randomScaled());
		end
		drainResults();
		readyMode = 2;
		idleCycle();
		for (int i = 0; i < holdOps; i++)
			issueOp(opAdd, randomScaled(), randomScaled());
		// Four items now fill the pipeline, so the input side must stall.
		repeat (3)
		begin
			@(negedge clock);
			checkValue(64'(opReady), 64'd0, "opReady with a full pipeline");
			@(posedge clock);
			#1;
		end
		readyMode = 0;
		finishTest("back-pressure");

		$display("checks passed: %0d, checks failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: common/fpuPkg.sv
// Covers binary64 without NaN or infinity handling, flushes denormals and rounds on one guard bit.
`default_nettype none

package fpuPkg;

	// ########################################
	// Operation codes
	// ########################################

	// The encoding follows the execute-stage opcode, where 0 is idle, 1 add, 2 subtract and 3 convert.
	typedef enum logic [1:0]
	{
		opNone = 2'd0,
		opAdd  = 2'd1,
		opSub  = 2'd2,
		opI2f  = 2'd3
	} fpuOp;

	// ########################################
	// Field widths
	// ########################################

	localparam int expWidth = 11;
	localparam int fracWidth = 52;
	localparam int workWidth = 64;

	// Beyond this exponent difference the smaller operand shifts out completely.
	localparam int maxAlignShift = 52;

	// Biased exponent of 2^63, the starting point for integer conversion.
	localparam int i2fExponent = 1086;

	// ########################################
	// Stage record layout
	// ########################################

	// The exponent carries one extra top bit, which flags a borrow after normalization.
	localparam int expStageWidth = expWidth + 1;

	// The working fraction holds the carry, the hidden bit, the stored fraction and the guard bits.
	localparam int carryBit = workWidth - 1;
	localparam int hiddenBit = workWidth - 2;
	localparam int guardWidth = workWidth - fracWidth - 2;

	// First bit below the packed fraction, used for rounding.
	localparam int roundBit = guardWidth - 1;

endpackage

`default_nettype wire

// File: common/fpuStageIf.sv
// Carries one item per valid and ready transfer; fields a later stage ignores hold don't-care values.
`default_nettype none

interface fpuStageIf
	import fpuPkg::*;
();

	logic valid;
	logic ready;
	fpuOp op;
	logic signA;
	logic signB;
	logic [expStageWidth-1:0] expA;
	logic [workWidth-1:0] fracA;
	logic [workWidth-1:0] fracB;

	// The producing stage owns the payload and valid.
	modport src
	(
		output valid,
		output op,
		output signA,
		output signB,
		output expA,
		output fracA,
		output fracB,
		input ready
	);

	// The consuming stage answers with ready.
	modport dst
	(
		input valid,
		input op,
		input signA,
		input signB,
		input expA,
		input fracA,
		input fracB,
		output ready
	);

endinterface

`default_nettype wire

// File: fpuAdd/fpuAlign.sv
// Zero exponents count as zero, and alignment truncates bits shifted below the guard bits.
`default_nettype none

module fpuAlign
	import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input fpuOp op,
	input logic [63:0] rn,
	input logic [63:0] rm,
	fpuStageIf.src out
);

	logic signN;
	logic signM;
	logic [expWidth-1:0] expN;
	logic [expWidth-1:0] expM;
	logic [workWidth-1:0] fracN;
	logic [workWidth-1:0] fracM;
	logic swap;
	logic [expWidth-1:0] bigExp;
	logic [expWidth-1:0] smallExp;
	logic [expWidth-1:0] expDiff;
	logic [workWidth-1:0] smallFrac;
	logic [workWidth-1:0] shiftedFrac;
	logic accept;

	// ########################################
	// Operand unpacking
	// ########################################

	// Subtraction is addition with the sign of rm flipped.
	assign signN = rn[63];
	assign signM = rm[63] ^ (op == opSub);
	assign expN = rn[62 -: expWidth];
	assign expM = rm[62 -: expWidth];

	// A zero exponent reads as zero, so denormal fractions are dropped.
	assign fracN = (expN != '0) ? {2'b01, rn[fracWidth-1:0], {guardWidth{1'b0}}} : '0;
	assign fracM = (expM != '0) ? {2'b01, rm[fracWidth-1:0], {guardWidth{1'b0}}} : '0;

	// Comparing whole magnitudes puts the larger exponent first, and for equal exponents
	// the larger fraction, so a later subtraction never goes negative.
	assign swap = rm[62:0] > rn[62:0];
	assign bigExp = swap ? expM : expN;
	assign smallExp = swap ? expN : expM;
	assign smallFrac = swap ? fracN : fracM;
	assign expDiff = bigExp - smallExp;
	assign shiftedFrac = (expDiff > maxAlignShift) ? '0 : smallFrac >> expDiff;

	// ########################################
	// Stage register
	// ########################################

	assign inReady = !out.valid || out.ready;
	assign accept = inValid && inReady;

	// Idle operations are taken but never stored.
	always_ff @(posedge clock)
	begin
		if (rst)
			out.valid <= 1'b0;
		else if (inReady)
			out.valid <= inValid && (op != opNone);
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			out.op <= op;
			if (op == opI2f)
			begin
				// The raw integer rides in fracA until the add stage takes its magnitude.
				out.signA <= 1'b0;
				out.signB <= 1'b0;
				out.expA <= expStageWidth'(i2fExponent);
				out.fracA <= rn;
				out.fracB <= '0;
			end
			else
			begin
				out.signA <= swap ? signM : signN;
				out.signB <= swap ? signN : signM;
				out.expA <= {1'b0, bigExp};
				out.fracA <= swap ? fracM : fracN;
				out.fracB <= shiftedFrac;
			end
		end
	end

endmodule

`default_nettype wire

// File: fpuAdd/fpuMantAdd.sv
// Expects fracA to be the larger magnitude; an integer of -2^63 is left to the carry path.
`default_nettype none

module fpuMantAdd
	import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	fpuStageIf.dst in,
	fpuStageIf.src out
);

	logic accept;
	logic sumSign;
	logic [expStageWidth-1:0] sumExp;
	logic [workWidth-1:0] sumFrac;

	assign in.ready = !out.valid || out.ready;
	assign accept = in.valid && in.ready;

	always_comb
	begin
		if (in.op == opI2f)
		begin
			// Two's complement input, so the top bit is the sign.
			sumSign = in.fracA[carryBit];
			sumFrac = sumSign ? -in.fracA : in.fracA;
			// Integer bit 62 lands on the hidden bit, worth 2^62 and one step below 2^63.
			sumExp = in.expA - 1'b1;
		end
		else
		begin
			sumSign = in.signA;
			sumExp = in.expA;
			if (in.signA == in.signB)
				sumFrac = in.fracA + in.fracB;
			else
				sumFrac = in.fracA - in.fracB;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			out.valid <= 1'b0;
		else if (in.ready)
			out.valid <= in.valid;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			out.op <= in.op;
			out.signA <= sumSign;
			out.expA <= sumExp;
			out.fracA <= sumFrac;
		end
	end

	// Only one fraction remains from here on.
	assign out.signB = 1'b0;
	assign out.fracB = '0;

endmodule

`default_nettype wire

// File: fpuAdd/fpuNormalize.sv
// Exponent overflow is not caught; an exponent driven below zero sets the borrow bit for rounding.
`default_nettype none

module fpuNormalize
	import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	fpuStageIf.dst in,
	fpuStageIf.src out
);

	localparam int numGroups = 8;

	logic accept;
	logic isZero;
	logic [2:0] coarseSteps;
	logic [2:0] fineSteps;
	logic [workWidth-1:0] coarseProbe;
	logic [workWidth-1:0] coarseFrac;
	logic normSign;
	logic [expStageWidth-1:0] normExp;
	logic [workWidth-1:0] normFrac;

	assign in.ready = !out.valid || out.ready;
	assign accept = in.valid && in.ready;
	assign isZero = in.fracA == '0;

	// ########################################
	// Leading-one search
	// ########################################

	// Bytes are counted down from the hidden bit. The lowest group has only seven bits,
	// so the loop runs from the bottom and the last hit is the highest nonzero group.
	always_comb
	begin
		coarseSteps = '0;
		coarseProbe = '0;
		for (int g = numGroups - 1; g >= 0; g--)
		begin
			coarseProbe = in.fracA << (8 * g);
			if (coarseProbe[hiddenBit -: 8] != 8'd0)
				coarseSteps = 3'(g);
		end
	end

	assign coarseFrac = in.fracA << {coarseSteps, 3'b000};

	// Fine step within the top byte after the coarse shift.
	always_comb
	begin
		fineSteps = 3'd7;
		for (int b = 0; b < 8; b++)
		begin
			if (coarseFrac[hiddenBit - 7 + b])
				fineSteps = 3'(7 - b);
		end
	end

	// ########################################
	// Normalized result
	// ########################################

	always_comb
	begin
		normSign = in.signA;
		if (in.fracA[carryBit])
		begin
			// Carry out of the add, one step right.
			normExp = in.expA + 1'b1;
			normFrac = in.fracA >> 1;
		end
		else if (isZero)
		begin
			// Exact cancellation gives +0.
			normSign = 1'b0;
			normExp = '0;
			normFrac = '0;
		end
		else
		begin
			normExp = in.expA - expStageWidth'({coarseSteps, 3'b000})
				- expStageWidth'(fineSteps);
			normFrac = coarseFrac << fineSteps;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			out.valid <= 1'b0;
		else if (in.ready)
			out.valid <= in.valid;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			out.op <= in.op;
			out.signA <= normSign;
			out.expA <= normExp;
			out.fracA <= normFrac;
		end
	end

	assign out.signB = 1'b0;
	assign out.fracB = '0;

endmodule

`default_nettype wire

// File: fpuAdd/fpuRound.sv
// Rounds half away from zero on one guard bit; any underflow returns +0 instead of a denormal.
`default_nettype none

module fpuRound
	import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	fpuStageIf.dst in,
	output logic resValid,
	input logic resReady,
	output logic [63:0] result
);

	logic accept;
	logic [63:0] packedWord;
	logic [63:0] rounded;

	assign in.ready = !resValid || resReady;
	assign accept = in.valid && in.ready;

	// The fraction field sits right below the hidden bit.
	assign packedWord = {in.signA, in.expA[expWidth-1:0], in.fracA[hiddenBit-1 -: fracWidth]};

	// A carry out of the fraction moves into the exponent field.
	assign rounded = packedWord + 64'(in.fracA[roundBit]);

	always_ff @(posedge clock)
	begin
		if (rst)
			resValid <= 1'b0;
		else if (in.ready)
			resValid <= in.valid;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			// The borrow bit marks an exponent that went below zero.
			if (in.expA[expStageWidth-1])
				result <= '0;
			else
				result <= rounded;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fpuAddTop.sv
// Results leave in issue order, four stage registers after acceptance; idle ops yield no result.
`default_nettype none

module fpuAddTop
	import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	input logic opValid,
	output logic opReady,
	input fpuOp op,
	input logic [63:0] rn,
	input logic [63:0] rm,
	output logic resValid,
	input logic resReady,
	output logic [63:0] result
);

	// ########################################
	// Stage links
	// ########################################

	fpuStageIf alignToAdd ();
	fpuStageIf addToNorm ();
	fpuStageIf normToRound ();

	// ########################################
	// Pipeline stages
	// ########################################

	fpuAlign align
	(
		.clock(clock),
		.rst(rst),
		.inValid(opValid),
		.inReady(opReady),
		.op(op),
		.rn(rn),
		.rm(rm),
		.out(alignToAdd.src)
	);

	fpuMantAdd mantAdd
	(
		.clock(clock),
		.rst(rst),
		.in(alignToAdd.dst),
		.out(addToNorm.src)
	);

	fpuNormalize normalize
	(
		.clock(clock),
		.rst(rst),
		.in(addToNorm.dst),
		.out(normToRound.src)
	);

	fpuRound round
	(
		.clock(clock),
		.rst(rst),
		.in(normToRound.dst),
		.resValid(resValid),
		.resReady(resReady),
		.result(result)
	);

endmodule

`default_nettype wire

// File: project.f
common/fpuPkg.sv
common/fpuStageIf.sv
fpuAdd/fpuAlign.sv
fpuAdd/fpuMantAdd.sv
fpuAdd/fpuNormalize.sv
fpuAdd/fpuRound.sv
hdl/fpuAddTop.sv
bench/fpuAddBench.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and checks the log for the pass message.
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module fpuAddBench \
	-f project.f --Mdir "$buildDir" -o fpuAddSim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$buildDir/fpuAddSim" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "Simulator exited with status $runStatus"
	exit 1
fi

if grep -qx "Simulation completed successfully" "$logFile"; then
	exit 0
fi
exit 1
